//--- addr_decode.sv
// Last matching rule wins; no match silently selects default_idx_i
`timescale 1ns/10ps
`include "xbar_cfg.svh"

module addr_decode (
  input  logic [31:0]                                     addr_i,
  input  xbar_pkg::addr_map_rule_t [`XBAR_NUM_RULES-1:0]  addr_map_i,
  input  xbar_pkg::slv_idx_t                              default_idx_i,
  output xbar_pkg::slv_idx_t                              idx_o
);
  import xbar_pkg::*;

  slv_idx_t hit_idx;
  logic     hit_any;

  // Scan in table order so later rules override earlier ones
  always_comb begin
    hit_idx = '0;
    hit_any = 1'b0;
    for (int unsigned r = 0; r < `XBAR_NUM_RULES; r++) begin
      // Half-open range check
      if ((addr_i >= addr_map_i[r].start_addr) && (addr_i < addr_map_i[r].end_addr)) begin
        hit_idx = addr_map_i[r].idx;
        hit_any = 1'b1;
      end
    end
  end

  // Decode errors are not reported, fall back instead
  assign idx_o = hit_any ? hit_idx : default_idx_i;

endmodule

//--- idx_fifo.sv
// In-order index FIFO; caller must not push when full or pop when empty
`timescale 1ns/10ps

module idx_fifo #(
  parameter int unsigned DEPTH = 4,
  parameter int unsigned WIDTH = 2
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             full_o,
  output logic             empty_o
);

  localparam int unsigned AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // Storage has no reset, count guards it
  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [AW-1:0]    wr_ptr_q;
  logic [AW-1:0]    rd_ptr_q;
  logic [AW:0]      cnt_q;

  assign full_o  = (cnt_q == (AW + 1)'(DEPTH));
  assign empty_o = (cnt_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap explicitly, DEPTH need not be a power of two
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (push_i && !pop_i) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop_i && !push_i) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i) push_i |-> !full_o)
    else $error("idx_fifo: push while full");
  a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i) pop_i |-> !empty_o)
    else $error("idx_fifo: pop while empty");

endmodule

//--- mem_bank.sv
// Single-port OBI memory, one request at a time, rvalid 1 to 4 cycles after gnt
// Only address bits 7:2 select the word; upper bits are ignored
`timescale 1ns/10ps
`include "xbar_cfg.svh"

module mem_bank #(
  parameter logic [7:0] LFSR_SEED = 8'hA5
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  obi_pkg::obi_req_t  req_i,
  output obi_pkg::obi_resp_t resp_o
);

  logic [31:0] mem_q [`BANK_WORDS];
  logic [5:0]  word;
  logic        accept;
  logic        rvalid;

  // Control state
  logic        busy_q;
  logic [1:0]  cnt_q;
  logic [7:0]  lfsr_q;
  // Response payload, captured at grant
  logic [31:0] rdata_q;

  assign word   = req_i.addr[7:2];
  assign accept = req_i.req && !busy_q;
  // Last cycle of the busy window
  assign rvalid = busy_q && (cnt_q == 2'd0);

  assign resp_o = '{gnt: accept, rvalid: rvalid, rdata: rvalid ? rdata_q : 32'h0};

  // ------------------------------------------------------------
  // Storage with byte enables
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (req_i.we) begin
        for (int unsigned b = 0; b < 4; b++) begin
          if (req_i.be[b]) begin
            mem_q[word][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
        rdata_q <= 32'h0;
      end else begin
        rdata_q <= mem_q[word];
      end
    end
  end

  // Busy window length drawn from the LFSR low bits
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
      cnt_q  <= 2'd0;
      lfsr_q <= LFSR_SEED;
    end else begin
      // x^8 + x^6 + x^5 + x^4 + 1, free running
      lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
      if (accept) begin
        busy_q <= 1'b1;
        cnt_q  <= lfsr_q[1:0];
      end else if (rvalid) begin
        busy_q <= 1'b0;
      end else if (busy_q) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

//--- obi_pkg.sv
// OBI request and response bundles, 32-bit address and data only
package obi_pkg;

  // ------------------------------------------------------------
  // Master to slave
  // ------------------------------------------------------------
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  // ------------------------------------------------------------
  // Slave to master
  // ------------------------------------------------------------
  // rvalid is a single-cycle pulse, rdata only meaningful with it
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_resp_t;

endpackage

//--- rr_arbiter.sv
// Round-robin arbiter for one output; data_t must be a packed type
`timescale 1ns/10ps

module rr_arbiter #(
  parameter int unsigned NUM_IN = 2,
  parameter type         data_t = logic
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic     [NUM_IN-1:0]   req_i,
  input  data_t    [NUM_IN-1:0]   data_i,
  input  logic                    gnt_i,
  output logic                    req_o,
  output data_t                   data_o,
  output logic     [NUM_IN-1:0]   gnt_o
);

  localparam int unsigned PTR_W = (NUM_IN > 1) ? $clog2(NUM_IN) : 1;

  logic [PTR_W-1:0] ptr_q;
  logic [PTR_W-1:0] win_idx;

  // ------------------------------------------------------------
  // Winner select
  // ------------------------------------------------------------
  // First requester at or after the pointer, wrapping around
  always_comb begin
    int unsigned cand;
    logic        found;
    cand    = 0;
    found   = 1'b0;
    win_idx = ptr_q;
    for (int unsigned k = 0; k < NUM_IN; k++) begin
      cand = (int'(ptr_q) + k) % NUM_IN;
      if (!found && req_i[cand]) begin
        win_idx = PTR_W'(cand);
        found   = 1'b1;
      end
    end
  end

  assign req_o  = |req_i;
  assign data_o = data_i[win_idx];
  // Grant only passes to the winner once downstream accepts
  assign gnt_o  = (gnt_i && req_o) ? (NUM_IN'(1) << win_idx) : '0;

  // Pointer moves one past the winner after an accepted request
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (gnt_i && req_o) begin
      ptr_q <= (win_idx == PTR_W'(NUM_IN - 1)) ? '0 : win_idx + 1'b1;
    end
  end

  // Grant goes to at most one input and only one that asked
  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(gnt_o) && ((gnt_o & ~req_i) == '0))
    else $error("rr_arbiter: bad grant vector %b for req %b", gnt_o, req_i);

endmodule

//--- src.f
+incdir+.
obi_pkg.sv
xbar_pkg.sv
addr_decode.sv
rr_arbiter.sv
idx_fifo.sv
xbar_varlat.sv
xbar_varlat_n_to_m.sv
mem_bank.sv
xbar_mem_top.sv
tb_xbar_mem_top.sv

//--- tb_xbar_mem_top.sv
// Table-driven OBI traffic through the crossbar, checked against a reference memory
// Reads only touch words written earlier, since bank storage powers up unknown
`timescale 1ns/10ps
`include "xbar_cfg.svh"

module tb_xbar_mem_top;
  import obi_pkg::*;
  import xbar_pkg::*;

  localparam int N_MST           = `XBAR_NMASTER;
  localparam int N_SLV           = `XBAR_MSLAVE;
  localparam int CLK_PERIOD      = 8;
  localparam int QTR             = CLK_PERIOD / 4;
  localparam int NUM_ROWS        = 26;
  localparam int NUM_GROUPS      = 8;
  localparam int DEFAULT_BANK    = 2;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * 20 + 100;

  // One stimulus row, the test name lives in a separate array
  typedef struct packed {
    logic [7:0]  grp;
    logic [7:0]  mst;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } row_t;

  logic                                 clk_i;
  logic                                 rst_i;
  obi_req_t  [N_MST-1:0]                master_req;
  obi_resp_t [N_MST-1:0]                master_resp;
  addr_map_rule_t [`XBAR_NUM_RULES-1:0] addr_map;
  slv_idx_t                             default_idx;

  row_t        rows [NUM_ROWS];
  string       names [NUM_ROWS];
  int          row_cnt;
  // Reference memory, bank then word
  logic [31:0] ref_mem [N_SLV][`BANK_WORDS];
  int          grant_log [$];
  int          vld_seen [N_MST];
  int          pass_cnt;
  int          fail_cnt;
  int          seed;

  xbar_mem_top u_xbar_mem_top (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .master_req_i  (master_req),
    .master_resp_o (master_resp),
    .addr_map_i    (addr_map),
    .default_idx_i (default_idx)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Run limit scales with table length
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, a request never finished", WATCHDOG_CYCLES);
    $display("Test failures found");
    $finish;
  end

  // Counts every rvalid pulse, sampled mid-cycle
  initial begin
    forever begin
      @(negedge clk_i);
      #(QTR);
      for (int m = 0; m < N_MST; m++) begin
        if (master_resp[m].rvalid) begin
          vld_seen[m]++;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("** Error %s: expected %08h, actual %08h", name, exp, act);
      fail_cnt++;
    end else begin
      $display("PASS %s: %08h", name, act);
      pass_cnt++;
    end
  endtask

  // Fixed map: rule i covers 0x100*i up to 0x100*(i+1), else the default bank
  function automatic int resolve_bank(input logic [31:0] addr);
    int bank;
    bank = DEFAULT_BANK;
    for (int i = 0; i < `XBAR_NUM_RULES; i++) begin
      if ((addr >= 32'(i) * 32'h100) && (addr < 32'(i + 1) * 32'h100)) begin
        bank = i;
      end
    end
    return bank;
  endfunction

  task automatic add_row(input string name, input int g, input int m, input logic we,
                         input logic [3:0] be, input logic [31:0] addr,
                         input logic [31:0] wdata);
    names[row_cnt] = name;
    rows[row_cnt]  = '{grp: 8'(g), mst: 8'(m), we: we, be: be, addr: addr, wdata: wdata};
    row_cnt++;
  endtask

  // One request: hold until gnt, then wait for its rvalid
  task automatic run_row(input int r);
    int          m;
    int          bank;
    int          word;
    bit          done;
    logic [31:0] exp;
    logic [31:0] got;
    m    = rows[r].mst;
    bank = resolve_bank(rows[r].addr);
    word = rows[r].addr[7:2];
    exp  = '0;
    got  = '0;
    @(negedge clk_i);
    master_req[m] = '{req: 1'b1, we: rows[r].we, be: rows[r].be,
                      addr: rows[r].addr, wdata: rows[r].wdata};
    done = 1'b0;
    while (!done) begin
      #(QTR);
      if (master_resp[m].gnt) begin
        done = 1'b1;
        grant_log.push_back(m);
      end
      @(negedge clk_i);
    end
    master_req[m].req = 1'b0;
    // Model update at grant, writes answer with zero
    if (rows[r].we) begin
      for (int b = 0; b < 4; b++) begin
        if (rows[r].be[b]) begin
          ref_mem[bank][word][8*b +: 8] = rows[r].wdata[8*b +: 8];
        end
      end
    end else begin
      exp = ref_mem[bank][word];
    end
    done = 1'b0;
    while (!done) begin
      #(QTR);
      if (master_resp[m].rvalid) begin
        done = 1'b1;
        got  = master_resp[m].rdata;
      end else begin
        @(negedge clk_i);
      end
    end
    check_value(names[r], exp, got);
  endtask

  // Rows of one master within a group, in table order
  task automatic run_master(input int g, input int m);
    for (int r = 0; r < NUM_ROWS; r++) begin
      if ((rows[r].grp == g) && (rows[r].mst == m)) begin
        run_row(r);
      end
    end
  endtask

  // Shared-bank group: first round of grants must cover every master once
  task automatic check_rounds(input int g);
    int               bank;
    bit               shared;
    bit [N_MST-1:0]   users;
    bit [N_MST-1:0]   seen;
    int               n_users;
    bank   = -1;
    shared = 1'b1;
    users  = '0;
    seen   = '0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (rows[r].grp == g) begin
        if (bank < 0) begin
          bank = resolve_bank(rows[r].addr);
        end else if (resolve_bank(rows[r].addr) != bank) begin
          shared = 1'b0;
        end
        users[rows[r].mst] = 1'b1;
      end
    end
    n_users = $countones(users);
    if (!shared || (n_users < 2)) begin
      return;
    end
    for (int k = 0; (k < n_users) && (k < grant_log.size()); k++) begin
      seen[grant_log[k]] = 1'b1;
    end
    check_value($sformatf("rr_round_g%0d", g), 32'(users), 32'(seen));
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    logic [N_MST-1:0] busy_bits;
    int               exp_n;
    seed        = 32'hd12;
    pass_cnt    = 0;
    fail_cnt    = 0;
    row_cnt     = 0;
    busy_bits   = '0;
    rst_i       = 1'b1;
    master_req  = '0;
    default_idx = slv_idx_t'(DEFAULT_BANK);
    for (int i = 0; i < `XBAR_NUM_RULES; i++) begin
      addr_map[i] = '{idx: slv_idx_t'(i), start_addr: 32'(i) * 32'h100,
                      end_addr: 32'(i + 1) * 32'h100};
    end

    // Write then read, one master
    add_row("wr_m0_b0", 0, 0, 1'b1, 4'hF, 32'h010, 32'hCAFE_0001);
    add_row("rd_m0_b0", 0, 0, 1'b0, 4'hF, 32'h010, 32'h0);
    // Partial write keeps bytes 3 and 1
    add_row("wr_full_b1", 1, 1, 1'b1, 4'hF, 32'h120, 32'h1122_3344);
    add_row("wr_be5_b1", 1, 1, 1'b1, 4'b0101, 32'h120, 32'hAABB_CCDD);
    add_row("rd_be_b1", 1, 1, 1'b0, 4'hF, 32'h120, 32'h0);
    // Parallel masters, separate banks
    add_row("par_wr_m0", 2, 0, 1'b1, 4'hF, 32'h034, $random(seed));
    add_row("par_wr_m1", 2, 1, 1'b1, 4'hF, 32'h138, $random(seed));
    add_row("par_wr_m2", 2, 2, 1'b1, 4'hF, 32'h33C, $random(seed));
    add_row("par_rd_m0", 3, 0, 1'b0, 4'hF, 32'h138, 32'h0);
    add_row("par_rd_m1", 3, 1, 1'b0, 4'hF, 32'h33C, 32'h0);
    add_row("par_rd_m2", 3, 2, 1'b0, 4'hF, 32'h034, 32'h0);
    // All masters on bank 3
    add_row("cnt_wr_m0a", 4, 0, 1'b1, 4'hF, 32'h300, $random(seed));
    add_row("cnt_wr_m0b", 4, 0, 1'b1, 4'hF, 32'h304, $random(seed));
    add_row("cnt_wr_m1a", 4, 1, 1'b1, 4'hF, 32'h308, $random(seed));
    add_row("cnt_wr_m1b", 4, 1, 1'b1, 4'hF, 32'h30C, $random(seed));
    add_row("cnt_wr_m2a", 4, 2, 1'b1, 4'hF, 32'h310, $random(seed));
    add_row("cnt_wr_m2b", 4, 2, 1'b1, 4'hF, 32'h314, $random(seed));
    add_row("cnt_rd_m0a", 5, 0, 1'b0, 4'hF, 32'h308, 32'h0);
    add_row("cnt_rd_m0b", 5, 0, 1'b0, 4'hF, 32'h314, 32'h0);
    add_row("cnt_rd_m1a", 5, 1, 1'b0, 4'hF, 32'h310, 32'h0);
    add_row("cnt_rd_m1b", 5, 1, 1'b0, 4'hF, 32'h300, 32'h0);
    add_row("cnt_rd_m2a", 5, 2, 1'b0, 4'hF, 32'h304, 32'h0);
    add_row("cnt_rd_m2b", 5, 2, 1'b0, 4'hF, 32'h30C, 32'h0);
    // Unmapped address, word offset 5, lands in bank 2
    add_row("dflt_wr_m2", 6, 2, 1'b1, 4'hF, 32'h1014, 32'h5EED_0005);
    add_row("dflt_rd_m0", 7, 0, 1'b0, 4'hF, 32'h214, 32'h0);
    add_row("dflt_rd_m1", 7, 1, 1'b0, 4'hF, 32'h1014, 32'h0);

    // Reset for 5 cycles, outputs quiet through the first cycle after
    for (int c = 0; c < 6; c++) begin
      @(negedge clk_i);
      if (c == 4) begin
        rst_i = 1'b0;
      end
      #(QTR);
      for (int m = 0; m < N_MST; m++) begin
        busy_bits[m] = busy_bits[m] | master_resp[m].gnt | master_resp[m].rvalid;
      end
    end
    check_value("reset_quiet", 32'h0, 32'(busy_bits));

    for (int g = 0; g < NUM_GROUPS; g++) begin
      grant_log.delete();
      for (int m = 0; m < N_MST; m++) begin
        automatic int mi = m;
        fork
          run_master(g, mi);
        join_none
      end
      wait fork;
      check_rounds(g);
    end

    // Settle, then one rvalid per issued request
    repeat (8) @(negedge clk_i);
    for (int m = 0; m < N_MST; m++) begin
      exp_n = 0;
      for (int r = 0; r < NUM_ROWS; r++) begin
        if (rows[r].mst == m) begin
          exp_n++;
        end
      end
      check_value($sformatf("rvalid_count_m%0d", m), 32'(exp_n), 32'(vld_seen[m]));
    end

    $display("Tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- xbar_cfg.svh
// Crossbar and bank sizing shared by packages and RTL
// Bank decode uses address bits 7:2, so BANK_WORDS must stay at 64
`ifndef XBAR_CFG_SVH
`define XBAR_CFG_SVH

// Port counts
`define XBAR_NMASTER 3
`define XBAR_MSLAVE 4

// Address map entries
`define XBAR_NUM_RULES 4

// 32-bit words per memory bank
`define BANK_WORDS 64

// Requests in flight per slave before back-pressure
`define XBAR_MAX_OUTST 4

`endif

//--- xbar_mem_top.sv
// Crossbar with one memory bank per slave port; bank latencies differ by seed
`timescale 1ns/10ps
`include "xbar_cfg.svh"

module xbar_mem_top (
  input  logic                                            clk_i,
  input  logic                                            rst_i,
  input  obi_pkg::obi_req_t  [`XBAR_NMASTER-1:0]          master_req_i,
  output obi_pkg::obi_resp_t [`XBAR_NMASTER-1:0]          master_resp_o,
  input  xbar_pkg::addr_map_rule_t [`XBAR_NUM_RULES-1:0]  addr_map_i,
  input  xbar_pkg::slv_idx_t                              default_idx_i
);
  import obi_pkg::*;

  // Crossbar to bank links
  obi_req_t  [`XBAR_MSLAVE-1:0] slv_req;
  obi_resp_t [`XBAR_MSLAVE-1:0] slv_resp;

  xbar_varlat_n_to_m u_xbar_varlat_n_to_m (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .addr_map_i    (addr_map_i),
    .default_idx_i (default_idx_i),
    .master_req_i  (master_req_i),
    .master_resp_o (master_resp_o),
    .slave_req_o   (slv_req),
    .slave_resp_i  (slv_resp)
  );

  // Distinct seeds so banks do not respond in lockstep
  for (genvar s = 0; s < `XBAR_MSLAVE; s++) begin : g_bank
    mem_bank #(
      .LFSR_SEED (8'hA5 + 8'(8'd37 * s))
    ) u_mem_bank (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .req_i  (slv_req[s]),
      .resp_o (slv_resp[s])
    );
  end

endmodule

//--- xbar_pkg.sv
// Crossbar address map and internal payload types
// Rule ranges include start_addr and exclude end_addr
`include "xbar_cfg.svh"

package xbar_pkg;

  // Index widths, never below one bit
  localparam int unsigned SLV_IDX_W = (`XBAR_MSLAVE > 1) ? $clog2(`XBAR_MSLAVE) : 1;
  localparam int unsigned MST_IDX_W = (`XBAR_NMASTER > 1) ? $clog2(`XBAR_NMASTER) : 1;

  typedef logic [SLV_IDX_W-1:0] slv_idx_t;

  // One entry of the run-time address map
  typedef struct packed {
    slv_idx_t    idx;
    logic [31:0] start_addr;
    logic [31:0] end_addr;
  } addr_map_rule_t;

  // Request fields forwarded by an arbiter, req strobe travels apart
  typedef struct packed {
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } xbar_req_payload_t;

endpackage

//--- xbar_varlat.sv
// Slaves must answer in grant order; if two slaves answer one master together
// the lower slave index is delivered and the other response is lost
`timescale 1ns/10ps
`include "xbar_cfg.svh"

module xbar_varlat (
  input  logic                                            clk_i,
  input  logic                                            rst_i,
  input  logic [`XBAR_NMASTER-1:0]                        req_i,
  input  xbar_pkg::slv_idx_t [`XBAR_NMASTER-1:0]          idx_i,
  input  xbar_pkg::xbar_req_payload_t [`XBAR_NMASTER-1:0] payload_i,
  output logic [`XBAR_NMASTER-1:0]                        gnt_o,
  output logic [`XBAR_NMASTER-1:0]                        vld_o,
  output logic [`XBAR_NMASTER-1:0][31:0]                  rdata_o,
  output logic [`XBAR_MSLAVE-1:0]                         slave_req_o,
  input  logic [`XBAR_MSLAVE-1:0]                         slave_gnt_i,
  input  logic [`XBAR_MSLAVE-1:0]                         slave_vld_i,
  input  logic [`XBAR_MSLAVE-1:0][31:0]                   slave_rdata_i,
  output xbar_pkg::xbar_req_payload_t [`XBAR_MSLAVE-1:0]  slave_payload_o
);
  import xbar_pkg::*;

  localparam int unsigned N_MST = `XBAR_NMASTER;
  localparam int unsigned N_SLV = `XBAR_MSLAVE;

  // Request matrix, slave-major, and its master-major transpose of grants
  logic [N_SLV-1:0][N_MST-1:0]     slv_reqs;
  logic [N_SLV-1:0][N_MST-1:0]     arb_gnt;
  logic [N_MST-1:0][N_SLV-1:0]     mst_gnt;
  logic [N_SLV-1:0]                arb_req;
  logic [N_SLV-1:0]                slv_accept;
  logic [N_SLV-1:0]                fifo_full;
  logic [N_SLV-1:0]                fifo_empty;
  // Master owed the oldest response of each slave
  logic [N_SLV-1:0][MST_IDX_W-1:0] head_idx;

  // ------------------------------------------------------------
  // Per-slave arbitration and order tracking
  // ------------------------------------------------------------
  for (genvar s = 0; s < N_SLV; s++) begin : g_slv
    logic [MST_IDX_W-1:0] win_idx;

    for (genvar m = 0; m < N_MST; m++) begin : g_mst
      assign slv_reqs[s][m] = req_i[m] && (idx_i[m] == SLV_IDX_W'(s));
      assign mst_gnt[m][s]  = arb_gnt[s][m];
    end

    rr_arbiter #(
      .NUM_IN (N_MST),
      .data_t (xbar_req_payload_t)
    ) u_rr_arbiter (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .req_i  (slv_reqs[s]),
      .data_i (payload_i),
      .gnt_i  (slv_accept[s]),
      .req_o  (arb_req[s]),
      .data_o (slave_payload_o[s]),
      .gnt_o  (arb_gnt[s])
    );

    // Back-pressure: no room to log a winner, no request to the slave
    assign slave_req_o[s] = arb_req[s] & ~fifo_full[s];
    assign slv_accept[s]  = slave_gnt_i[s] & slave_req_o[s];

    // One-hot grant to binary master index
    always_comb begin
      win_idx = '0;
      for (int unsigned m = 0; m < N_MST; m++) begin
        if (arb_gnt[s][m]) begin
          win_idx = MST_IDX_W'(m);
        end
      end
    end

    idx_fifo #(
      .DEPTH (`XBAR_MAX_OUTST),
      .WIDTH (MST_IDX_W)
    ) u_idx_fifo (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .push_i  (slv_accept[s]),
      .data_i  (win_idx),
      .pop_i   (slave_vld_i[s]),
      .data_o  (head_idx[s]),
      .full_o  (fifo_full[s]),
      .empty_o (fifo_empty[s])
    );

    // Response with nothing outstanding means the slave broke ordering
    a_vld_has_owner: assert property (@(posedge clk_i) disable iff (rst_i)
      slave_vld_i[s] |-> !fifo_empty[s])
      else $error("xbar_varlat: rvalid from slave %0d with empty FIFO", s);
  end

  // ------------------------------------------------------------
  // Grant return
  // ------------------------------------------------------------
  for (genvar m = 0; m < N_MST; m++) begin : g_gnt
    assign gnt_o[m] = |mst_gnt[m];

    // A master's single request must not land in two slaves
    a_single_slave_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
      $onehot0(mst_gnt[m]))
      else $error("xbar_varlat: master %0d granted by several slaves", m);
  end

  // Response routing through FIFO heads, lowest slave first
  always_comb begin
    vld_o   = '0;
    rdata_o = '0;
    for (int unsigned m = 0; m < N_MST; m++) begin
      for (int unsigned s = 0; s < N_SLV; s++) begin
        if (!vld_o[m] && slave_vld_i[s] && (head_idx[s] == MST_IDX_W'(m))) begin
          vld_o[m]   = 1'b1;
          rdata_o[m] = slave_rdata_i[s];
        end
      end
    end
  end

endmodule

//--- xbar_varlat_n_to_m.sv
// OBI N-to-M crossbar; unmatched addresses go to default_idx_i, no error response
`timescale 1ns/10ps
`include "xbar_cfg.svh"

module xbar_varlat_n_to_m (
  input  logic                                            clk_i,
  input  logic                                            rst_i,
  input  xbar_pkg::addr_map_rule_t [`XBAR_NUM_RULES-1:0]  addr_map_i,
  input  xbar_pkg::slv_idx_t                              default_idx_i,
  input  obi_pkg::obi_req_t  [`XBAR_NMASTER-1:0]          master_req_i,
  output obi_pkg::obi_resp_t [`XBAR_NMASTER-1:0]          master_resp_o,
  output obi_pkg::obi_req_t  [`XBAR_MSLAVE-1:0]           slave_req_o,
  input  obi_pkg::obi_resp_t [`XBAR_MSLAVE-1:0]           slave_resp_i
);
  import xbar_pkg::*;

  localparam int unsigned N_MST = `XBAR_NMASTER;
  localparam int unsigned N_SLV = `XBAR_MSLAVE;

  // Master side, split out of OBI
  logic              [N_MST-1:0]       mst_req;
  slv_idx_t          [N_MST-1:0]       mst_idx;
  xbar_req_payload_t [N_MST-1:0]       mst_payload;
  logic              [N_MST-1:0]       mst_gnt;
  logic              [N_MST-1:0]       mst_vld;
  logic              [N_MST-1:0][31:0] mst_rdata;

  // Slave side
  logic              [N_SLV-1:0]       slv_req;
  xbar_req_payload_t [N_SLV-1:0]       slv_payload;
  logic              [N_SLV-1:0]       slv_gnt;
  logic              [N_SLV-1:0]       slv_vld;
  logic              [N_SLV-1:0][31:0] slv_rdata;

  // ------------------------------------------------------------
  // Master ports: decode and pack
  // ------------------------------------------------------------
  for (genvar m = 0; m < N_MST; m++) begin : g_mst
    addr_decode u_addr_decode (
      .addr_i        (master_req_i[m].addr),
      .addr_map_i    (addr_map_i),
      .default_idx_i (default_idx_i),
      .idx_o         (mst_idx[m])
    );

    assign mst_req[m]     = master_req_i[m].req;
    assign mst_payload[m] = '{we:    master_req_i[m].we,
                              be:    master_req_i[m].be,
                              addr:  master_req_i[m].addr,
                              wdata: master_req_i[m].wdata};
    assign master_resp_o[m] = '{gnt: mst_gnt[m], rvalid: mst_vld[m], rdata: mst_rdata[m]};
  end

  // Slave ports: rebuild OBI from arbiter output
  for (genvar s = 0; s < N_SLV; s++) begin : g_slv
    assign slave_req_o[s] = '{req:   slv_req[s],
                              we:    slv_payload[s].we,
                              be:    slv_payload[s].be,
                              addr:  slv_payload[s].addr,
                              wdata: slv_payload[s].wdata};
    assign slv_gnt[s]   = slave_resp_i[s].gnt;
    assign slv_vld[s]   = slave_resp_i[s].rvalid;
    assign slv_rdata[s] = slave_resp_i[s].rdata;
  end

  xbar_varlat u_xbar_varlat (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .req_i           (mst_req),
    .idx_i           (mst_idx),
    .payload_i       (mst_payload),
    .gnt_o           (mst_gnt),
    .vld_o           (mst_vld),
    .rdata_o         (mst_rdata),
    .slave_req_o     (slv_req),
    .slave_gnt_i     (slv_gnt),
    .slave_vld_i     (slv_vld),
    .slave_rdata_i   (slv_rdata),
    .slave_payload_o (slv_payload)
  );

endmodule
